//--- Bender.yml
package:
  name: dma_rx

sources:
  # RTL in compile order, packages first
  - logic/dma_rx_cfg_pkg.sv
  - logic/dma_rx_types_pkg.sv
  - logic/rx_realign.sv
  - logic/rx_desc_gen.sv
  - logic/dma_rx_top.sv
  - target: test
    files:
      - dv/dma_rx_chk.sv
      - dv/dma_rx_tb.sv

//--- dma_rx.f
logic/dma_rx_cfg_pkg.sv
logic/dma_rx_types_pkg.sv
logic/rx_realign.sv
logic/rx_desc_gen.sv
logic/dma_rx_top.sv
dv/dma_rx_chk.sv
dv/dma_rx_tb.sv

//--- dv/dma_rx_chk.sv
`timescale 1ns/1ns
`default_nettype none

// Handshake rules on the write port and the descriptor port of dma_rx_top
module dma_rx_chk (
  input logic                         clk,
  input logic                         rst,
  input dma_rx_types_pkg::mem_wr_t    mem_wr,
  input logic                         mem_wr_en,
  input logic                         mem_wr_ready,
  input dma_rx_types_pkg::recv_desc_t recv_desc,
  input logic                         recv_desc_valid,
  input logic                         recv_desc_ready
);

  // Number of assertion failures seen so far, read by the testbench at the end
  int fail_count = 0;

  // A stalled write request keeps every field until memory takes it
  wr_hold_a: assert property (@(posedge clk) disable iff (rst)
    (mem_wr_en && !mem_wr_ready) |=> (mem_wr_en && $stable(mem_wr)))
  else begin
    fail_count++;
    $error("mem_wr changed or dropped while mem_wr_ready was low");
  end

  // Same rule for a descriptor that has not been taken yet
  desc_hold_a: assert property (@(posedge clk) disable iff (rst)
    (recv_desc_valid && !recv_desc_ready) |=> (recv_desc_valid && $stable(recv_desc)))
  else begin
    fail_count++;
    $error("recv_desc changed or dropped while recv_desc_ready was low");
  end

  // Nothing may be offered in the cycle after a reset cycle
  reset_idle_a: assert property (@(posedge clk)
    rst |=> (!mem_wr_en && !recv_desc_valid))
  else begin
    fail_count++;
    $error("mem_wr_en or recv_desc_valid high right after reset");
  end

endmodule

bind dma_rx_top dma_rx_chk chk_i (
  .clk             (clk),
  .rst             (rst),
  .mem_wr          (mem_wr),
  .mem_wr_en       (mem_wr_en),
  .mem_wr_ready    (mem_wr_ready),
  .recv_desc       (recv_desc),
  .recv_desc_valid (recv_desc_valid),
  .recv_desc_ready (recv_desc_ready)
);

`default_nettype wire

//--- dv/dma_rx_tb.sv
`timescale 1ns/1ns
`default_nettype none

// Random packets into the receive DMA, checked against a byte memory model
module dma_rx_tb;

  localparam int num_pkts       = 40;
  localparam int max_len        = 40;
  localparam int region_size    = 256;
  localparam int timeout_cycles = num_pkts * 50;
  localparam int wb             = dma_rx_cfg_pkg::strb_width;

  logic                                  clk;
  logic                                  rst;
  dma_rx_types_pkg::axis_beat_t          s_axis;
  logic                                  s_axis_tvalid;
  logic                                  s_axis_tready;
  logic [dma_rx_cfg_pkg::dest_width-1:0] s_axis_tdest;
  logic [dma_rx_cfg_pkg::user_width-1:0] s_axis_tuser;
  logic [dma_rx_cfg_pkg::addr_width-1:0] wr_base_addr;
  dma_rx_types_pkg::mem_wr_t             mem_wr;
  logic                                  mem_wr_en;
  logic                                  mem_wr_ready;
  dma_rx_types_pkg::recv_desc_t          recv_desc;
  logic                                  recv_desc_valid;
  logic                                  recv_desc_ready;

  integer seed;
  int     cycle_count;
  // Descriptors taken so far and the packet whose writes are in flight
  int     desc_count;
  int     wr_pkt;

  // Byte memory as the DUT should leave it
  logic [7:0] mem_model [0:65535];
  // Bytes of each packet in stream order
  logic [7:0] pkt_bytes [0:num_pkts-1][0:max_len-1];
  // Start and length of every packet, used to bound the strobes
  dma_rx_types_pkg::recv_desc_t pkt_desc [0:num_pkts-1];
  dma_rx_types_pkg::recv_desc_t exp_desc [$];

  dma_rx_top dut_i (
    .clk             (clk),
    .rst             (rst),
    .s_axis          (s_axis),
    .s_axis_tvalid   (s_axis_tvalid),
    .s_axis_tready   (s_axis_tready),
    .s_axis_tdest    (s_axis_tdest),
    .s_axis_tuser    (s_axis_tuser),
    .wr_base_addr    (wr_base_addr),
    .mem_wr          (mem_wr),
    .mem_wr_en       (mem_wr_en),
    .mem_wr_ready    (mem_wr_ready),
    .recv_desc       (recv_desc),
    .recv_desc_valid (recv_desc_valid),
    .recv_desc_ready (recv_desc_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic int rand_below(input int n);
    return {$random(seed)} % n;
  endfunction

  // Unwritten bytes carry a value tied to their full address
  task automatic fill_memory();
    int i;
    for (i = 0; i < 65536; i++) begin
      mem_model[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
    end
  endtask

  // Advance one clock and pick new ready levels for both outputs
  task automatic next_cycle();
    @(posedge clk);
    mem_wr_ready    <= (rand_below(4) != 0);
    recv_desc_ready <= (rand_below(3) != 0);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic send_packet(input int idx);
    int                                    len;
    int                                    offs;
    int                                    nbeats;
    int                                    kept;
    int                                    b;
    int                                    i;
    logic [dma_rx_cfg_pkg::addr_width-1:0] base;
    logic [dma_rx_cfg_pkg::dest_width-1:0] dest;
    logic [dma_rx_cfg_pkg::user_width-1:0] user;
    dma_rx_types_pkg::axis_beat_t          beat;
    dma_rx_types_pkg::recv_desc_t          desc;
    len  = 1 + rand_below(max_len);
    // Offset leaves room for the tail word inside the packet's own region
    offs = rand_below(region_size - max_len - 2 * wb);
    base = dma_rx_cfg_pkg::addr_width'(idx * region_size + offs);
    dest = dma_rx_cfg_pkg::dest_width'(rand_below(256));
    user = dma_rx_cfg_pkg::user_width'(rand_below(4));
    desc.addr  = base;
    desc.len   = dma_rx_cfg_pkg::len_width'(len);
    desc.tdest = dest;
    desc.tuser = user;
    pkt_desc[idx] = desc;
    exp_desc.push_back(desc);
    nbeats = (len + wb - 1) / wb;
    for (b = 0; b < nbeats; b++) begin
      kept = (len - b * wb > wb) ? wb : len - b * wb;
      // Lanes past keep hold junk that must never reach memory
      for (i = 0; i < wb; i++) begin
        beat.data[8*i +: 8] = 8'(rand_below(256));
        if (i < kept) begin
          pkt_bytes[idx][b*wb + i] = beat.data[8*i +: 8];
        end
      end
      beat.keep = dma_rx_cfg_pkg::strb_width'((1 << kept) - 1);
      beat.last = (b == nbeats - 1);
      while (rand_below(4) == 0) begin
        s_axis_tvalid <= 1'b0;
        next_cycle();
      end
      s_axis        <= beat;
      s_axis_tvalid <= 1'b1;
      if (b == 0) begin
        s_axis_tdest <= dest;
        s_axis_tuser <= user;
        wr_base_addr <= base;
      end else begin
        // Later beats carry junk sideband so only the first beat may be sampled
        s_axis_tdest <= dma_rx_cfg_pkg::dest_width'(rand_below(256));
        s_axis_tuser <= dma_rx_cfg_pkg::user_width'(rand_below(4));
        wr_base_addr <= dma_rx_cfg_pkg::addr_width'(rand_below(65536));
      end
      next_cycle();
      while (!(s_axis_tvalid && s_axis_tready)) begin
        next_cycle();
      end
    end
  endtask

  ////////////////////
  // Model
  ////////////////////

  // Every strobed byte must fall inside the packet being written
  task automatic apply_write();
    int i;
    int a;
    int lo;
    int hi;
    check_value("mem_wr.addr byte lane bits",
                64'(mem_wr.addr[dma_rx_cfg_pkg::mask_bits-1:0]), 64'd0);
    if (wr_pkt >= num_pkts) begin
      fail_run("A write request arrived after every packet had finished");
    end else begin
      lo = int'(pkt_desc[wr_pkt].addr);
      hi = lo + int'(pkt_desc[wr_pkt].len);
      for (i = 0; i < wb; i++) begin
        if (mem_wr.strb[i]) begin
          a = int'(mem_wr.addr) + i;
          if (a < lo || a >= hi) begin
            fail_run($sformatf("Write to byte 0x%0h lies outside packet %0d", a, wr_pkt));
          end
          mem_model[a] = mem_wr.data[8*i +: 8];
        end
      end
      if (mem_wr.last) begin
        wr_pkt++;
      end
    end
  endtask

  task automatic take_desc();
    int                           i;
    dma_rx_types_pkg::recv_desc_t exp;
    if (exp_desc.size() == 0) begin
      fail_run("A descriptor arrived with no packet outstanding");
    end else begin
      exp = exp_desc.pop_front();
      check_value("recv_desc.addr", 64'(recv_desc.addr), 64'(exp.addr));
      check_value("recv_desc.len", 64'(recv_desc.len), 64'(exp.len));
      check_value("recv_desc.tdest", 64'(recv_desc.tdest), 64'(exp.tdest));
      check_value("recv_desc.tuser", 64'(recv_desc.tuser), 64'(exp.tuser));
      // Packet bytes must sit in order from the start address on
      for (i = 0; i < int'(exp.len); i++) begin
        check_value($sformatf("memory byte 0x%0h of packet %0d", int'(exp.addr) + i,
                              desc_count),
                    64'(mem_model[int'(exp.addr) + i]), 64'(pkt_bytes[desc_count][i]));
      end
      desc_count++;
    end
  endtask

  // Values read here are the ones that were present at the clock edge
  always @(posedge clk) begin
    if (!rst) begin
      if (mem_wr_en && mem_wr_ready) begin
        apply_write();
      end
      if (recv_desc_valid && recv_desc_ready) begin
        take_desc();
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      fail_run($sformatf("Timeout after %0d cycles with %0d of %0d descriptors received",
                         cycle_count, desc_count, num_pkts));
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int p;
    seed            = 32'hfd30_29a2;
    cycle_count     = 0;
    desc_count      = 0;
    wr_pkt          = 0;
    rst             = 1'b1;
    s_axis          = '0;
    s_axis_tvalid   = 1'b0;
    s_axis_tdest    = '0;
    s_axis_tuser    = '0;
    wr_base_addr    = '0;
    mem_wr_ready    = 1'b0;
    recv_desc_ready = 1'b0;
    fill_memory();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (p = 0; p < num_pkts; p++) begin
      send_packet(p);
    end
    s_axis_tvalid <= 1'b0;
    // Keep toggling the readies until the last descriptor is taken
    while (desc_count < num_pkts) begin
      next_cycle();
    end
    if (wr_pkt != num_pkts || dut_i.chk_i.fail_count != 0) begin
      fail_run("Run ended with packets unaccounted for or a failed assertion");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- logic/dma_rx_cfg_pkg.sv
`default_nettype none

// Sizing of the receive DMA engine
// Every width in the design is derived from the values below
package dma_rx_cfg_pkg;

  // Bits per stream beat and per memory word
  localparam int data_width = 64;

  // One keep bit and one write strobe bit per byte
  localparam int strb_width = data_width / 8;

  // Low address bits that select a byte inside a word
  localparam int mask_bits = $clog2(strb_width);

  // Byte address into the target memory
  localparam int addr_width = 16;

  // Packet length reported in the receive descriptor
  localparam int len_width = 16;

  // Sideband fields copied from the input stream
  localparam int dest_width = 8;
  localparam int user_width = 2;

endpackage

`default_nettype wire

//--- logic/dma_rx_top.sv
`timescale 1ns/1ns
`default_nettype none

// Receive side of the stream to memory DMA
module dma_rx_top (
  input  logic                                  clk,
  input  logic                                  rst,
  input  dma_rx_types_pkg::axis_beat_t          s_axis,
  input  logic                                  s_axis_tvalid,
  output logic                                  s_axis_tready,
  input  logic [dma_rx_cfg_pkg::dest_width-1:0] s_axis_tdest,
  input  logic [dma_rx_cfg_pkg::user_width-1:0] s_axis_tuser,
  input  logic [dma_rx_cfg_pkg::addr_width-1:0] wr_base_addr,
  output dma_rx_types_pkg::mem_wr_t             mem_wr,
  output logic                                  mem_wr_en,
  input  logic                                  mem_wr_ready,
  output dma_rx_types_pkg::recv_desc_t          recv_desc,
  output logic                                  recv_desc_valid,
  input  logic                                  recv_desc_ready
);

  logic [dma_rx_cfg_pkg::data_width-1:0] wr_data;
  logic [dma_rx_cfg_pkg::strb_width-1:0] wr_strb;
  logic [dma_rx_cfg_pkg::addr_width-1:0] wr_addr;
  logic                                  wr_last;
  logic                                  wr_fire;
  logic                                  first_beat;
  logic                                  desc_block;
  dma_rx_types_pkg::pkt_meta_t           pkt_meta;

  // Data path and stream handshake
  rx_realign realign_i (
    .clk           (clk),
    .rst           (rst),
    .s_axis        (s_axis),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdest  (s_axis_tdest),
    .s_axis_tuser  (s_axis_tuser),
    .wr_base_addr  (wr_base_addr),
    .mem_wr_ready  (mem_wr_ready),
    .desc_block    (desc_block),
    .mem_wr_en     (mem_wr_en),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb),
    .wr_last       (wr_last),
    .wr_fire       (wr_fire),
    .first_beat    (first_beat),
    .pkt_meta      (pkt_meta)
  );

  // Addressing and descriptor bookkeeping
  rx_desc_gen desc_gen_i (
    .clk             (clk),
    .rst             (rst),
    .wr_fire         (wr_fire),
    .first_beat      (first_beat),
    .wr_last         (wr_last),
    .wr_strb         (wr_strb),
    .pkt_meta        (pkt_meta),
    .recv_desc_ready (recv_desc_ready),
    .wr_addr         (wr_addr),
    .desc_block      (desc_block),
    .recv_desc_valid (recv_desc_valid),
    .recv_desc       (recv_desc)
  );

  // The address comes from the descriptor side and the rest from the pipeline
  assign mem_wr = '{addr: wr_addr, data: wr_data, strb: wr_strb, last: wr_last};

endmodule

`default_nettype wire

//--- logic/dma_rx_types_pkg.sv
`default_nettype none

// Bundles passed between the DMA blocks and across the top level ports
package dma_rx_types_pkg;

  // One beat of the byte-keyed input stream
  // Bytes are packed from bit 0 upward and keep marks the valid ones
  typedef struct packed {
    logic [dma_rx_cfg_pkg::data_width-1:0] data;
    logic [dma_rx_cfg_pkg::strb_width-1:0] keep;
    logic                                  last;
  } axis_beat_t;

  // Per-packet information sampled together with the first input beat
  typedef struct packed {
    logic [dma_rx_cfg_pkg::addr_width-1:0] addr;
    logic [dma_rx_cfg_pkg::dest_width-1:0] tdest;
    logic [dma_rx_cfg_pkg::user_width-1:0] tuser;
  } pkt_meta_t;

  // A single write request towards memory
  // The address is always word aligned and strb selects the bytes to update
  typedef struct packed {
    logic [dma_rx_cfg_pkg::addr_width-1:0] addr;
    logic [dma_rx_cfg_pkg::data_width-1:0] data;
    logic [dma_rx_cfg_pkg::strb_width-1:0] strb;
    logic                                  last;
  } mem_wr_t;

  // Receive descriptor issued once per finished packet
  // addr is the unaligned start address and len the byte count
  typedef struct packed {
    logic [dma_rx_cfg_pkg::addr_width-1:0] addr;
    logic [dma_rx_cfg_pkg::len_width-1:0]  len;
    logic [dma_rx_cfg_pkg::dest_width-1:0] tdest;
    logic [dma_rx_cfg_pkg::user_width-1:0] tuser;
  } recv_desc_t;

endpackage

`default_nettype wire

//--- logic/rx_desc_gen.sv
`timescale 1ns/1ns
`default_nettype none

// Write address, packet length and the receive descriptor
// A descriptor finished while the previous one is still waiting is parked
// and handed over as soon as the waiting one is taken
module rx_desc_gen (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  wr_fire,
  input  logic                                  first_beat,
  input  logic                                  wr_last,
  input  logic [dma_rx_cfg_pkg::strb_width-1:0] wr_strb,
  input  dma_rx_types_pkg::pkt_meta_t           pkt_meta,
  input  logic                                  recv_desc_ready,
  output logic [dma_rx_cfg_pkg::addr_width-1:0] wr_addr,
  output logic                                  desc_block,
  output logic                                  recv_desc_valid,
  output dma_rx_types_pkg::recv_desc_t          recv_desc
);

  logic [dma_rx_cfg_pkg::addr_width-1:0] next_addr;
  logic [dma_rx_cfg_pkg::addr_width-1:0] start_word;

  logic [dma_rx_cfg_pkg::mask_bits:0]    beat_bytes;
  logic [dma_rx_cfg_pkg::len_width-1:0]  beat_len;
  logic [dma_rx_cfg_pkg::len_width-1:0]  pkt_len;
  logic [dma_rx_cfg_pkg::len_width-1:0]  next_len;

  logic                                  last_fire;
  logic                                  load_now;
  logic                                  load_late;
  logic                                  late_write;
  dma_rx_types_pkg::recv_desc_t          done_desc;
  dma_rx_types_pkg::recv_desc_t          pend_desc;

  ////////////////////
  // Write address
  ////////////////////

  // Start address with the byte lane bits cleared
  assign start_word = {pkt_meta.addr[dma_rx_cfg_pkg::addr_width-1:dma_rx_cfg_pkg::mask_bits],
                       {dma_rx_cfg_pkg::mask_bits{1'b0}}};

  assign wr_addr = first_beat ? start_word : next_addr;

  // Every accepted write moves on by one word
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      next_addr <= wr_addr + dma_rx_cfg_pkg::addr_width'(dma_rx_cfg_pkg::strb_width);
    end
  end

  ////////////////////
  // Length
  ////////////////////

  // Strobes need not be contiguous so each bit is counted
  always_comb begin
    beat_bytes = '0;
    for (int i = 0; i < dma_rx_cfg_pkg::strb_width; i++) begin
      if (wr_strb[i]) begin
        beat_bytes = beat_bytes + 1'b1;
      end
    end
  end

  assign beat_len = {{(dma_rx_cfg_pkg::len_width - dma_rx_cfg_pkg::mask_bits - 1){1'b0}},
                     beat_bytes};

  // The first write restarts the count
  assign next_len = first_beat ? beat_len : pkt_len + beat_len;

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      pkt_len <= next_len;
    end
  end

  ////////////////////
  // Descriptor
  ////////////////////

  // Metadata is still that of the finishing packet during its last write
  always_comb begin
    done_desc.addr  = pkt_meta.addr;
    done_desc.len   = next_len;
    done_desc.tdest = pkt_meta.tdest;
    done_desc.tuser = pkt_meta.tuser;
  end

  assign desc_block = recv_desc_valid && !recv_desc_ready;
  assign last_fire  = wr_fire && wr_last;
  assign load_now   = last_fire && !desc_block;
  assign load_late  = late_write && recv_desc_ready;

  always_ff @(posedge clk) begin
    if (load_now) begin
      recv_desc <= done_desc;
    end else if (load_late) begin
      recv_desc <= pend_desc;
    end
    if (last_fire && desc_block) begin
      pend_desc <= done_desc;
    end
  end

  // At most one descriptor is parked since the next last beat is held off
  always_ff @(posedge clk) begin
    if (rst) begin
      late_write      <= 1'b0;
      recv_desc_valid <= 1'b0;
    end else begin
      if (last_fire && desc_block) begin
        late_write <= 1'b1;
      end else if (recv_desc_ready) begin
        late_write <= 1'b0;
      end
      if (load_now || load_late) begin
        recv_desc_valid <= 1'b1;
      end else if (recv_desc_ready) begin
        recv_desc_valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/rx_realign.sv
`timescale 1ns/1ns
`default_nettype none

// Turns the input stream into word aligned memory writes
// The first byte of each packet is shifted to the byte lane given by the base address
module rx_realign (
  input  logic                                  clk,
  input  logic                                  rst,
  input  dma_rx_types_pkg::axis_beat_t          s_axis,
  input  logic                                  s_axis_tvalid,
  output logic                                  s_axis_tready,
  input  logic [dma_rx_cfg_pkg::dest_width-1:0] s_axis_tdest,
  input  logic [dma_rx_cfg_pkg::user_width-1:0] s_axis_tuser,
  input  logic [dma_rx_cfg_pkg::addr_width-1:0] wr_base_addr,
  input  logic                                  mem_wr_ready,
  input  logic                                  desc_block,
  output logic                                  mem_wr_en,
  output logic [dma_rx_cfg_pkg::data_width-1:0] wr_data,
  output logic [dma_rx_cfg_pkg::strb_width-1:0] wr_strb,
  output logic                                  wr_last,
  output logic                                  wr_fire,
  output logic                                  first_beat,
  output dma_rx_types_pkg::pkt_meta_t           pkt_meta
);

  // High between the first accepted beat and the last write of a packet
  logic in_pkt;
  logic in_fire;
  logic latch_meta;

  // Number of bytes of the first memory word that the packet fills
  // Ranges from 1 to strb_width so it needs one extra bit
  logic [dma_rx_cfg_pkg::mask_bits:0] offset;
  logic [dma_rx_cfg_pkg::mask_bits:0] base_offset;

  // Set when the newest beat has keep bytes beyond the current word
  logic strb_left;

  // Two-stage pipeline holding the newest beat and the one before
  logic [dma_rx_cfg_pkg::data_width-1:0]   data_1;
  logic [dma_rx_cfg_pkg::data_width-1:0]   data_2;
  logic [dma_rx_cfg_pkg::strb_width-1:0]   keep_1;
  logic [dma_rx_cfg_pkg::strb_width-1:0]   keep_2;
  logic                                    last_1;
  logic [2*dma_rx_cfg_pkg::data_width-1:0] data_pair;
  logic [2*dma_rx_cfg_pkg::strb_width-1:0] keep_pair;

  // The extra beat flushes the tail left in stage 2
  logic extra_beat;
  logic extra_beat_r;

  ////////////////////
  // Framing
  ////////////////////

  assign in_fire    = s_axis_tvalid && s_axis_tready;
  assign latch_meta = (!in_pkt || (wr_last && mem_wr_ready)) && in_fire;
  assign wr_fire    = mem_wr_en && mem_wr_ready;

  // Distance from the base address to the next word boundary
  assign base_offset = {1'b1, {dma_rx_cfg_pkg::mask_bits{1'b0}}} -
                       {1'b0, wr_base_addr[dma_rx_cfg_pkg::mask_bits-1:0]};

  // The tail needs its own write when the last beat spills into the next word
  assign extra_beat = last_1 && strb_left;

  // Last write is either the last beat itself or the extra beat after it
  assign wr_last = mem_wr_en && ((last_1 && !extra_beat) || extra_beat_r);

  // Input stalls on memory back-pressure and for one cycle on an extra beat
  // A last beat also waits while the previous descriptor is still not taken
  assign s_axis_tready = mem_wr_ready && !extra_beat && !(s_axis.last && desc_block);

  always_ff @(posedge clk) begin
    if (rst) begin
      in_pkt <= 1'b0;
    end else if (!in_pkt && in_fire) begin
      in_pkt <= 1'b1;
    end else if (in_pkt && wr_last && mem_wr_ready && !in_fire) begin
      in_pkt <= 1'b0;
    end
  end

  // Metadata and offset stay fixed for the whole packet
  always_ff @(posedge clk) begin
    if (latch_meta) begin
      pkt_meta.addr  <= wr_base_addr;
      pkt_meta.tdest <= s_axis_tdest;
      pkt_meta.tuser <= s_axis_tuser;
      offset         <= base_offset;
    end
  end

  ////////////////////
  // Pipeline
  ////////////////////

  // The first beat of a packet uses the offset that is not yet registered
  always_ff @(posedge clk) begin
    if (rst) begin
      strb_left <= 1'b0;
    end else if (extra_beat && wr_fire) begin
      strb_left <= 1'b0;
    end else if (latch_meta) begin
      strb_left <= |(s_axis.keep >> base_offset);
    end else if (in_fire) begin
      strb_left <= |(s_axis.keep >> offset);
    end
  end

  // Stage 1 is emptied when the extra beat goes out so it is not written twice
  always_ff @(posedge clk) begin
    if (rst) begin
      keep_1       <= '0;
      last_1       <= 1'b0;
      keep_2       <= '0;
      extra_beat_r <= 1'b0;
    end else begin
      if (extra_beat && wr_fire) begin
        keep_1 <= '0;
        last_1 <= 1'b0;
      end else if (in_fire) begin
        keep_1 <= s_axis.keep;
        last_1 <= s_axis.last;
      end
      // Stage 2 is cleared after the last write so the next packet starts clean
      if (wr_last && mem_wr_ready) begin
        keep_2 <= '0;
      end else if (wr_fire) begin
        keep_2 <= keep_1;
      end
      if (wr_fire) begin
        extra_beat_r <= extra_beat;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      data_1 <= s_axis.data;
    end
    if (wr_fire) begin
      data_2 <= data_1;
    end
  end

  // A write is pending after an accepted beat, after an extra beat is due,
  // or while memory has not taken the current one
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wr_en  <= 1'b0;
      first_beat <= 1'b0;
    end else begin
      mem_wr_en  <= in_fire || (wr_fire && extra_beat) || (mem_wr_en && !mem_wr_ready);
      first_beat <= latch_meta || (first_beat && !mem_wr_ready);
    end
  end

  // The upper stage supplies the high lanes and the older stage the low lanes
  assign data_pair = {data_1, data_2} >> {offset, 3'd0};
  assign keep_pair = {keep_1, keep_2} >> offset;
  assign wr_data   = data_pair[dma_rx_cfg_pkg::data_width-1:0];
  assign wr_strb   = keep_pair[dma_rx_cfg_pkg::strb_width-1:0];

endmodule

`default_nettype wire
